// File: fractalPkg.sv
/* Fixed-point types, frame geometry and stream structs for the fractal core.
   Coordinates are signed 36-bit values with 4 integer and 32 fraction bits. */
`default_nettype none

package fractalPkg;

  typedef logic signed [35:0] fixCoord;

  localparam int screenWidth  = 32;
  localparam int screenHeight = 16;

  typedef logic [4:0] screenX;
  typedef logic [3:0] screenY;

  localparam fixCoord baseStepX = 36'sh0_1800_0000; // 3.0 / 32 per column at zoom 0.
  localparam fixCoord baseStepY = 36'sh0_2000_0000; // 2.0 / 16 per row at zoom 0.

  localparam int zoomBits = 5;

  typedef logic [4:0] iterCount;
  localparam iterCount maxIter = 5'd31;

  // Squared magnitude bound, 4.0 on the same scale, with two guard bits.
  localparam logic signed [37:0] escapeLimit = 38'sh4_0000_0000;

  typedef struct packed {
    screenX  x;
    screenY  y;
    fixCoord re;
    fixCoord im;
  } coordItem;

  typedef struct packed {
    screenX   x;
    screenY   y;
    iterCount iterations;
  } pixelItem;

  typedef struct packed {
    fixCoord             upperLeftRe;
    fixCoord             upperLeftIm;
    logic [zoomBits-1:0] zoom;
  } viewConfig;

endpackage

`default_nettype wire

// File: wbPkg.sv
/* Wishbone classic host port structs and the register map of the core.
   Addresses are word indices on a 3-bit bus. */
`default_nettype none

package wbPkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] datW;
  } wbReq;

  typedef struct packed {
    logic        ack;
    logic [31:0] datR;
  } wbRsp;

  localparam logic [2:0] regReLow   = 3'd0;
  localparam logic [2:0] regReHigh  = 3'd1; // Only bits 3:0 are kept.
  localparam logic [2:0] regImLow   = 3'd2;
  localparam logic [2:0] regImHigh  = 3'd3; // Only bits 3:0 are kept.
  localparam logic [2:0] regZoom    = 3'd4;

  // Write bit 0 to start a frame. Read back bit 0 busy and bit 1 done.
  localparam logic [2:0] regControl = 3'd5;

endpackage

`default_nettype wire

// File: renderRegs.sv
/* Wishbone classic slave holding the view and control registers.
   Every access is acked once, one cycle after the request. A start while busy is ignored. */
`default_nettype none
`timescale 1ns/1ns

module renderRegs import wbPkg::*, fractalPkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  wbReq      wbIn,
  output wbRsp      wbOut,
  output viewConfig view,
  output logic      start,
  input  logic      frameDone
);

  logic [31:0]         reLow;
  logic [31:0]         imLow;
  logic [3:0]          reHigh;
  logic [3:0]          imHigh;
  logic [zoomBits-1:0] zoom;
  logic                busy;
  logic                done;
  logic                access;
  logic                writeAccess;
  logic                startReq;
  logic [31:0]         readData;

  // A strobe still high during the ack cycle is not a new access.
  assign access      = wbIn.cyc && wbIn.stb && !wbOut.ack;
  assign writeAccess = access && wbIn.we;
  assign startReq    = writeAccess && (wbIn.adr == regControl) && wbIn.datW[0] && !busy;

  always_comb begin
    case (wbIn.adr)
      regReLow:   readData = reLow;
      regReHigh:  readData = {28'd0, reHigh};
      regImLow:   readData = imLow;
      regImHigh:  readData = {28'd0, imHigh};
      regZoom:    readData = {{(32 - zoomBits){1'b0}}, zoom};
      regControl: readData = {30'd0, done, busy};
      default:    readData = '0; // Unmapped words read as zero.
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbOut  <= '0;
      start  <= 1'b0;
      busy   <= 1'b0;
      done   <= 1'b0;
      reLow  <= '0;
      reHigh <= '0;
      imLow  <= '0;
      imHigh <= '0;
      zoom   <= '0;
    end else begin
      wbOut.ack <= access;
      if (access) begin
        wbOut.datR <= wbIn.we ? 32'd0 : readData;
      end
      if (writeAccess) begin
        case (wbIn.adr)
          regReLow:  reLow  <= wbIn.datW;
          regReHigh: reHigh <= wbIn.datW[3:0];
          regImLow:  imLow  <= wbIn.datW;
          regImHigh: imHigh <= wbIn.datW[3:0];
          regZoom:   zoom   <= wbIn.datW[zoomBits-1:0];
          default:   ;
        endcase
      end
      start <= startReq; // Lines up with the ack of the control write.
      if (startReq) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (frameDone) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  assign view = '{upperLeftRe: {reHigh, reLow}, upperLeftIm: {imHigh, imLow}, zoom: zoom};

  // Each classic access must see exactly one ack, even with stb held.
  ackSinglePulse: assert property (@(posedge clk) disable iff (!arstN)
    wbOut.ack |=> !wbOut.ack)
    else $error("Wishbone ack held high for two cycles.");

endmodule

`default_nettype wire

// File: coordGenerator.sv
/* Raster scan over the 32 x 16 frame, one coordinate per handshake.
   The view is sampled at start, and a start outside idle has no effect. */
`default_nettype none
`timescale 1ns/1ns

module coordGenerator import fractalPkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  logic      start,
  input  viewConfig view,
  output logic      coordValid,
  output coordItem  coordOut,
  input  logic      coordReady,
  input  logic      lastPixelOut,
  output logic      frameDone
);

  typedef enum logic [1:0] {
    genIdle,
    genPresent,
    genDrained
  } genState;

  genState state;
  fixCoord rowStartRe;
  fixCoord stepX;
  fixCoord stepY;
  logic    transfer;
  logic    rowEnd;
  logic    lastCoord;

  assign transfer  = coordValid && coordReady;
  assign rowEnd    = coordOut.x == screenX'(screenWidth - 1);
  assign lastCoord = rowEnd && (coordOut.y == screenY'(screenHeight - 1));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state      <= genIdle;
      coordValid <= 1'b0;
      frameDone  <= 1'b0;
    end else begin
      frameDone <= 1'b0;
      case (state)
        genIdle: begin
          if (start) begin
            coordValid <= 1'b1;
            state      <= genPresent;
          end
        end
        genPresent: begin
          if (transfer && lastCoord) begin
            coordValid <= 1'b0;
            state      <= genDrained;
          end
        end
        genDrained: begin
          // The last pixel is still in the iterator until it reports it left.
          if (lastPixelOut) begin
            frameDone <= 1'b1;
            state     <= genIdle;
          end
        end
        default: state <= genIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == genIdle && start) begin
      rowStartRe <= view.upperLeftRe;
      stepX      <= baseStepX >>> view.zoom; // Zoom halves the step per level.
      stepY      <= baseStepY >>> view.zoom;
      coordOut   <= '{x: '0, y: '0, re: view.upperLeftRe, im: view.upperLeftIm};
    end else if (transfer && !lastCoord) begin
      if (rowEnd) begin
        coordOut.x  <= '0;
        coordOut.y  <= coordOut.y + 1'b1;
        coordOut.re <= rowStartRe;
        coordOut.im <= coordOut.im + stepY;
      end else begin
        coordOut.x  <= coordOut.x + 1'b1;
        coordOut.re <= coordOut.re + stepX;
      end
    end
  end

  // A stalled coordinate must not change before the iterator takes it.
  coordHeldStable: assert property (@(posedge clk) disable iff (!arstN)
    coordValid && !coordReady |=> coordValid && $stable(coordOut))
    else $error("Coordinate changed while stalled.");

endmodule

`default_nettype wire

// File: escapeIterator.sv
/* Escape-count engine for one point at a time, one z^2 + c step per clock.
   Squares keep bits 67:32 of the full product, so large values wrap. */
`default_nettype none
`timescale 1ns/1ns

module escapeIterator import fractalPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  logic     coordValid,
  input  coordItem coordIn,
  output logic     coordReady,
  output logic     pixelValid,
  output pixelItem pixelOut,
  input  logic     pixelReady,
  output logic     lastPixelOut
);

  typedef enum logic [1:0] {
    itEmpty,
    itRun,
    itResult
  } iterState;

  iterState           state;
  fixCoord            cRe;
  fixCoord            cIm;
  fixCoord            zRe;
  fixCoord            zIm;
  iterCount           count;
  screenX             pixX;
  screenY             pixY;
  logic signed [71:0] prodReRe;
  logic signed [71:0] prodImIm;
  logic signed [71:0] prodReIm;
  fixCoord            sqRe;
  fixCoord            sqIm;
  fixCoord            crossTerm;
  logic signed [37:0] magnitude;
  logic               escaped;

  assign prodReRe  = zRe * zRe;
  assign prodImIm  = zIm * zIm;
  assign prodReIm  = zRe * zIm;
  assign sqRe      = prodReRe[67:32]; // Arithmetic shift by 32, then truncation.
  assign sqIm      = prodImIm[67:32];
  assign crossTerm = prodReIm[67:32];
  assign magnitude = 38'(sqRe) + 38'(sqIm);

  // Tested before each step, so the count is the number of steps taken.
  assign escaped = (magnitude > escapeLimit) || (count == maxIter);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= itEmpty;
    end else begin
      case (state)
        itEmpty:  if (coordValid) state <= itRun;
        itRun:    if (escaped) state <= itResult;
        itResult: if (pixelReady) state <= itEmpty;
        default:  state <= itEmpty;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == itEmpty && coordValid) begin
      cRe   <= coordIn.re;
      cIm   <= coordIn.im;
      zRe   <= '0;
      zIm   <= '0;
      count <= '0;
      pixX  <= coordIn.x;
      pixY  <= coordIn.y;
    end else if (state == itRun && !escaped) begin
      zRe   <= sqRe - sqIm + cRe;
      zIm   <= (crossTerm <<< 1) + cIm; // 2 * re * im.
      count <= count + 1'b1;
    end
  end

  assign coordReady = state == itEmpty;
  assign pixelValid = state == itResult;
  assign pixelOut   = '{x: pixX, y: pixY, iterations: count};

  // The generator waits on this to close the frame.
  assign lastPixelOut = pixelValid && pixelReady
                        && (pixX == screenX'(screenWidth - 1))
                        && (pixY == screenY'(screenHeight - 1));

  // Reaching the limit must end the run, so the counter never wraps past maxIter.
  iterLimitStop: assert property (@(posedge clk) disable iff (!arstN)
    state == itRun && count == maxIter |=> state == itResult)
    else $error("Iteration count ran past maxIter.");

endmodule

`default_nettype wire

// File: fractalTop.sv
/* Core top with a Wishbone host port and a valid/ready pixel stream.
   Frame size and iteration limit are fixed in the package. */
`default_nettype none
`timescale 1ns/1ns

module fractalTop import wbPkg::*, fractalPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  wbReq     wbIn,
  output wbRsp     wbOut,
  output logic     pixelValid,
  output pixelItem pixelOut,
  input  logic     pixelReady
);

  viewConfig view;
  coordItem  coordBus;
  logic      start;
  logic      frameDone;
  logic      coordValid;
  logic      coordReady;
  logic      lastPixelOut;

  renderRegs regs_i (
    .clk(clk), .arstN(arstN),
    .wbIn(wbIn), .wbOut(wbOut),
    .view(view), .start(start), .frameDone(frameDone)
  );

  coordGenerator gen_i (
    .clk(clk), .arstN(arstN), .start(start), .view(view),
    .coordValid(coordValid), .coordOut(coordBus), .coordReady(coordReady),
    .lastPixelOut(lastPixelOut), .frameDone(frameDone)
  );

  escapeIterator iter_i (
    .clk(clk), .arstN(arstN),
    .coordValid(coordValid), .coordIn(coordBus), .coordReady(coordReady),
    .pixelValid(pixelValid), .pixelOut(pixelOut), .pixelReady(pixelReady),
    .lastPixelOut(lastPixelOut)
  );

endmodule

`default_nettype wire

// File: tbClock.sv
/* Free-running 8 ns clock. Reset is held low for the first two rising edges. */
`default_nettype none
`timescale 1ns/1ns

module tbClock (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    arstN = 1'b0;
    repeat (2) @(posedge clk);
    arstN <= 1'b1;
  end

endmodule

`default_nettype wire

// File: fractalTb.sv
/* Testbench for fractalTop: register access and three frames checked against a reference model.
   Back-pressure comes from an LCG, and the run stops at the first error. */
`default_nettype none
`timescale 1ns/1ns

module fractalTb import wbPkg::*, fractalPkg::*; ();

  localparam int framePixels   = screenWidth * screenHeight;
  localparam int frameCount    = 3;
  localparam int timeoutCycles = frameCount * (framePixels * (int'(maxIter) + 2) * 3 + 200);

  logic        clk;
  logic        arstN;
  wbReq        wbIn = '0;
  wbRsp        wbOut;
  logic        pixelValid;
  pixelItem    pixelOut;
  logic        pixelReady = 1'b0;
  logic        stallEnable = 1'b0;
  logic [31:0] rng = 32'h7e29;
  viewConfig   expView = '0;
  int          acceptedTotal = 0;
  int          frameStart = -framePixels; // No frame open yet, so any pixel counts as extra.
  int          cycles = 0;

  tbClock clock_i (.clk(clk), .arstN(arstN));

  fractalTop dut_i (
    .clk(clk), .arstN(arstN), .wbIn(wbIn), .wbOut(wbOut),
    .pixelValid(pixelValid), .pixelOut(pixelOut), .pixelReady(pixelReady)
  );

  task automatic stopOnError(string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  function automatic logic [31:0] nextRand(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Full signed product, arithmetic shift right by 32, keep the low 36 bits.
  function automatic fixCoord fixMul(fixCoord a, fixCoord b);
    logic signed [71:0] full;
    logic signed [71:0] scaled;
    full   = a * b;
    scaled = full >>> 32;
    return scaled[35:0];
  endfunction

  function automatic iterCount refIterations(fixCoord cRe, fixCoord cIm);
    fixCoord            zRe;
    fixCoord            zIm;
    fixCoord            reSq;
    fixCoord            imSq;
    fixCoord            reIm;
    logic signed [37:0] mag;
    int                 n;
    zRe = '0;
    zIm = '0;
    for (n = 0; n < int'(maxIter); n++) begin
      reSq = fixMul(zRe, zRe);
      imSq = fixMul(zIm, zIm);
      mag  = {{2{reSq[35]}}, reSq} + {{2{imSq[35]}}, imSq};
      if (mag > escapeLimit) return iterCount'(n); // Escaped before taking step n.
      reIm = fixMul(zRe, zIm);
      zRe  = reSq - imSq + cRe;
      zIm  = reIm + reIm + cIm;
    end
    return maxIter;
  endfunction

  // Expected pixel for a raster index of the current view.
  function automatic pixelItem expectedPixel(int idx);
    fixCoord re;
    fixCoord im;
    fixCoord stepX;
    fixCoord stepY;
    int      col;
    int      row;
    int      i;
    col   = idx % screenWidth;
    row   = idx / screenWidth;
    stepX = baseStepX >>> expView.zoom;
    stepY = baseStepY >>> expView.zoom;
    re    = expView.upperLeftRe;
    im    = expView.upperLeftIm;
    for (i = 0; i < col; i++) re = re + stepX;
    for (i = 0; i < row; i++) im = im + stepY;
    return '{x: screenX'(col), y: screenY'(row), iterations: refIterations(re, im)};
  endfunction

  task automatic checkPixel(pixelItem got, pixelItem exp);
    if (got !== exp) begin
      stopOnError($sformatf(
        "mismatch at %0t ns: pixelOut got x=%0d y=%0d it=%0d expected x=%0d y=%0d it=%0d",
        $time, got.x, got.y, got.iterations, exp.x, exp.y, exp.iterations));
    end
  endtask

  task automatic checkReg(wbRsp got, logic [31:0] exp, string name);
    if (got.datR !== exp) begin
      stopOnError($sformatf("mismatch at %0t ns: %s datR got 0x%08h expected 0x%08h",
                            $time, name, got.datR, exp));
    end
  endtask

  // One classic access. The ack is sampled on the falling edge.
  task automatic busCycle(logic we, logic [2:0] adr, logic [31:0] dat, output wbRsp rsp);
    int waited;
    @(posedge clk);
    wbIn <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, datW: dat};
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wbOut.ack && waited < 4);
    if (!wbOut.ack) stopOnError("No Wishbone ack arrived within 4 cycles.");
    rsp = wbOut;
    @(posedge clk);
    wbIn <= '0;
  endtask

  task automatic writeReg(logic [2:0] adr, logic [31:0] dat);
    wbRsp rsp;
    busCycle(1'b1, adr, dat, rsp);
  endtask

  task automatic readReg(logic [2:0] adr, output wbRsp rsp);
    busCycle(1'b0, adr, 32'd0, rsp);
  endtask

  task automatic startFrame(fixCoord re, fixCoord im, logic [zoomBits-1:0] zoom);
    writeReg(regReLow, re[31:0]);
    writeReg(regReHigh, {28'd0, re[35:32]});
    writeReg(regImLow, im[31:0]);
    writeReg(regImHigh, {28'd0, im[35:32]});
    writeReg(regZoom, {{(32 - zoomBits){1'b0}}, zoom});
    expView    = '{upperLeftRe: re, upperLeftIm: im, zoom: zoom};
    frameStart = acceptedTotal;
    writeReg(regControl, 32'h1);
  endtask

  task automatic finishFrame();
    wbRsp rsp;
    int   polls;
    wait (acceptedTotal - frameStart == framePixels);
    polls = 0;
    readReg(regControl, rsp);
    while (rsp.datR[1] !== 1'b1 && polls < 8) begin // frameDone lags the last pixel.
      readReg(regControl, rsp);
      polls++;
    end
    checkReg(rsp, 32'h2, "control status after frame");
  endtask

  always @(posedge clk) begin
    if (stallEnable) begin
      rng        <= nextRand(rng);
      pixelReady <= rng[31:16] >= 16'd21845; // Low about one cycle in three.
    end else begin
      pixelReady <= 1'b1;
    end
  end

  // Both handshake signals change only on rising edges, so the falling edge sees a transfer.
  always @(negedge clk) begin
    if (arstN && pixelValid && pixelReady) begin
      if (acceptedTotal - frameStart >= framePixels) begin
        stopOnError("A pixel was accepted after the frame was already complete.");
      end else begin
        checkPixel(pixelOut, expectedPixel(acceptedTotal - frameStart));
        acceptedTotal <= acceptedTotal + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeoutCycles) begin
      stopOnError($sformatf("Timeout after %0d cycles before the test finished.", cycles));
    end
  end

  initial begin
    wbRsp rsp;
    wait (arstN === 1'b1);
    readReg(regControl, rsp);
    checkReg(rsp, 32'h0, "control status after reset");
    writeReg(regReLow, 32'h89ab_cdef);
    writeReg(regReHigh, 32'hffff_fff5);
    writeReg(regImLow, 32'h1357_9bdf);
    writeReg(regImHigh, 32'h1234_567a);
    writeReg(regZoom, 32'h0000_00f6);
    readReg(regReLow, rsp);
    checkReg(rsp, 32'h89ab_cdef, "reLow");
    readReg(regReHigh, rsp);
    checkReg(rsp, 32'h5, "reHigh");
    readReg(regImLow, rsp);
    checkReg(rsp, 32'h1357_9bdf, "imLow");
    readReg(regImHigh, rsp);
    checkReg(rsp, 32'ha, "imHigh");
    readReg(regZoom, rsp);
    checkReg(rsp, 32'h16, "zoom");
    readReg(3'd6, rsp);
    checkReg(rsp, 32'h0, "unmapped word");

    // Corner (-2.0, -1.0) at zoom 0 with the sink always ready.
    startFrame(36'shE_0000_0000, 36'shF_0000_0000, 5'd0);
    finishFrame();

    // Corner (-0.75, -0.25) at zoom 3 under random back-pressure.
    stallEnable <= 1'b1;
    startFrame(36'shF_4000_0000, 36'shF_C000_0000, 5'd3);
    readReg(regControl, rsp);
    checkReg(rsp, 32'h1, "control status during frame");
    finishFrame();

    // New view and a second start in mid-frame must not disturb the running frame.
    startFrame(36'shE_8000_0000, 36'shF_8000_0000, 5'd1);
    wait (acceptedTotal - frameStart == 40);
    writeReg(regReLow, 32'h4000_0000);
    writeReg(regReHigh, 32'h0);
    writeReg(regImLow, 32'h8000_0000);
    writeReg(regZoom, 32'h2);
    writeReg(regControl, 32'h1);
    finishFrame();
    readReg(regReLow, rsp);
    checkReg(rsp, 32'h4000_0000, "reLow written during frame");
    repeat (100) @(posedge clk); // A pixel from the ignored start would show up as extra.

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
fractalPkg.sv
wbPkg.sv
renderRegs.sv
coordGenerator.sv
escapeIterator.sv
fractalTop.sv
tbClock.sv
fractalTb.sv

// File: run.sh
#!/bin/sh
# Builds the fractal core testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fractalTb -f list.f -o simFractal
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/simFractal > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus."
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a result line."
  exit 1
fi
exit 0
